//--- fetch_front_end.f
+incdir+source
source/fe_pkg.sv
source/branch_predictor.sv
source/instruction_buffer.sv
source/fetch_pc_gen.sv
source/fetch_front_end.sv
tb/fetch_front_end_asserts.sv
tb/fetch_front_end_tb.sv

//--- source/branch_predictor.sv
// ====================
// Direct-mapped branch target buffer with 2-bit saturating counters
// Lookup is combinational on lookup_pc_i, training happens on resolve_i
// ====================

`timescale 1ns/1ps

`include "fe_defs.svh"

module branch_predictor (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  fe_pkg::addr_t       lookup_pc_i,
    output fe_pkg::prediction_t prediction_o,
    input  fe_pkg::resolve_t    resolve_i
);

    import fe_pkg::*;

    // Tag covers every address bit above the index
    localparam int TAG_BITS = `FE_XLEN - `FE_BTB_INDEX_BITS - 2;

    logic [`FE_BTB_ENTRIES-1:0] valid_q;
    logic [TAG_BITS-1:0]        tag_q [`FE_BTB_ENTRIES];
    addr_t                      target_q [`FE_BTB_ENTRIES];
    counter_t                   counter_q [`FE_BTB_ENTRIES];

    btb_index_t          lookup_idx;
    btb_index_t          train_idx;
    logic [TAG_BITS-1:0] lookup_tag;
    logic [TAG_BITS-1:0] train_tag;
    logic                train_hit;

// ====================
// Lookup
// ====================

    assign lookup_idx = lookup_pc_i[`FE_BTB_INDEX_BITS+1:2];
    assign lookup_tag = lookup_pc_i[`FE_XLEN-1:`FE_BTB_INDEX_BITS+2];

    always_comb begin
        prediction_o.hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
        // Upper counter bit set means the counter sits at 2 or 3
        prediction_o.taken  = prediction_o.hit && counter_q[lookup_idx][1];
        prediction_o.target = target_q[lookup_idx];
    end

// ====================
// Training
// ====================

    assign train_idx = resolve_i.pc[`FE_BTB_INDEX_BITS+1:2];
    assign train_tag = resolve_i.pc[`FE_XLEN-1:`FE_BTB_INDEX_BITS+2];
    assign train_hit = valid_q[train_idx] && (tag_q[train_idx] == train_tag);

    // Only a taken branch that missed gets a new entry
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (resolve_i.valid && !train_hit && resolve_i.taken) begin
            valid_q[train_idx] <= 1'b1;
        end
    end

    // Tags, targets and counters only mean something while the entry is valid
    always_ff @(posedge clk_i) begin
        if (resolve_i.valid) begin
            if (train_hit) begin
                // Step toward the outcome and saturate at both ends
                if (resolve_i.taken && counter_q[train_idx] != 2'd3) begin
                    counter_q[train_idx] <= counter_q[train_idx] + 2'd1;
                end else if (!resolve_i.taken && counter_q[train_idx] != 2'd0) begin
                    counter_q[train_idx] <= counter_q[train_idx] - 2'd1;
                end
                if (resolve_i.taken) begin
                    target_q[train_idx] <= resolve_i.target;
                end
            end else if (resolve_i.taken) begin
                // New entry starts weakly taken
                tag_q[train_idx]     <= train_tag;
                target_q[train_idx]  <= resolve_i.target;
                counter_q[train_idx] <= 2'd2;
            end
        end
    end

endmodule

//--- source/fe_defs.svh
// ====================
// Widths, reset address and table sizes for the fetch front end
// Included by the package and by every module that sizes storage from them
// ====================

`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// Address and instruction width, RV32 only
`define FE_XLEN 32

// First address fetched once reset is released
`define FE_RESET_PC 32'h0000_0000

// Number of items the instruction buffer can hold
`define FE_IBUF_DEPTH 4

// Branch target buffer geometry
`define FE_BTB_ENTRIES 16

// The index is taken from address bits 5:2
`define FE_BTB_INDEX_BITS 4

`endif

//--- source/fe_pkg.sv
// ====================
// Shared types of the fetch front end
// Modules import it inside their body and use scoped names on their ports
// ====================

`include "fe_defs.svh"

package fe_pkg;

    // Plain vectors with a meaning of their own
    typedef logic [`FE_XLEN-1:0] addr_t;
    typedef logic [`FE_XLEN-1:0] instr_t;
    typedef logic [`FE_BTB_INDEX_BITS-1:0] btb_index_t;

    // Saturating counter, values 2 and 3 mean taken
    typedef logic [1:0] counter_t;

    // Free slot count of the buffer, wide enough to hold the full depth
    typedef logic [$clog2(`FE_IBUF_DEPTH + 1)-1:0] slot_cnt_t;

    // Predictor answer for one fetch address
    typedef struct packed {
        logic  hit;
        logic  taken;
        addr_t target;
    } prediction_t;

    // One fetched instruction together with the prediction made for it
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
        logic   pred_taken;
        addr_t  pred_target;
    } fetch_item_t;

    // Branch outcome from the back end, the prediction is echoed back
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
        logic  pred_taken;
        addr_t pred_target;
    } resolve_t;

    // Four-phase handshake states, used on the memory and the issue port
    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_RELEASE
    } hs_state_t;

endpackage

//--- source/fetch_front_end.sv
// ====================
// Top of the fetch front end
// Connects the PC generator, the branch predictor and the instruction buffer
// ====================

`timescale 1ns/1ps

module fetch_front_end (
    input  logic                clk_i,
    input  logic                rst_n_i,
    output logic                mem_req_o,
    output fe_pkg::addr_t       mem_addr_o,
    input  logic                mem_ack_i,
    input  fe_pkg::instr_t      mem_data_i,
    output logic                issue_req_o,
    output fe_pkg::fetch_item_t issue_item_o,
    input  logic                issue_ack_i,
    input  logic                trap_i,
    input  fe_pkg::addr_t       trap_pc_i,
    input  fe_pkg::resolve_t    resolve_i
);

    import fe_pkg::*;

    // Prediction path between PC generator and BTB
    addr_t       lookup_pc;
    prediction_t prediction;

    // Write path and back-pressure between PC generator and buffer
    logic        flush;
    logic        write;
    fetch_item_t write_item;
    slot_cnt_t   free_slots;

    fetch_pc_gen fetch_pc_gen_i (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .mem_req_o    ( mem_req_o  ),
        .mem_addr_o   ( mem_addr_o ),
        .mem_ack_i    ( mem_ack_i  ),
        .mem_data_i   ( mem_data_i ),
        .trap_i       ( trap_i     ),
        .trap_pc_i    ( trap_pc_i  ),
        .resolve_i    ( resolve_i  ),
        .lookup_pc_o  ( lookup_pc  ),
        .prediction_i ( prediction ),
        .free_slots_i ( free_slots ),
        .flush_o      ( flush      ),
        .write_o      ( write      ),
        .write_item_o ( write_item )
    );

    // Trained straight from the back end, in parallel with the redirect
    branch_predictor branch_predictor_i (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .lookup_pc_i  ( lookup_pc  ),
        .prediction_o ( prediction ),
        .resolve_i    ( resolve_i  )
    );

    instruction_buffer instruction_buffer_i (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .flush_i      ( flush        ),
        .write_i      ( write        ),
        .write_item_i ( write_item   ),
        .free_slots_o ( free_slots   ),
        .issue_req_o  ( issue_req_o  ),
        .issue_item_o ( issue_item_o ),
        .issue_ack_i  ( issue_ack_i  )
    );

endmodule

//--- source/fetch_pc_gen.sv
// ====================
// Program counter, next address choice and the four-phase memory port
// Writes each returned word with its prediction into the instruction buffer
// ====================

`timescale 1ns/1ps

`include "fe_defs.svh"

module fetch_pc_gen (
    input  logic                clk_i,
    input  logic                rst_n_i,
    output logic                mem_req_o,
    output fe_pkg::addr_t       mem_addr_o,
    input  logic                mem_ack_i,
    input  fe_pkg::instr_t      mem_data_i,
    input  logic                trap_i,
    input  fe_pkg::addr_t       trap_pc_i,
    input  fe_pkg::resolve_t    resolve_i,
    output fe_pkg::addr_t       lookup_pc_o,
    input  fe_pkg::prediction_t prediction_i,
    input  fe_pkg::slot_cnt_t   free_slots_i,
    output logic                flush_o,
    output logic                write_o,
    output fe_pkg::fetch_item_t write_item_o
);

    import fe_pkg::*;

    hs_state_t state_q;
    addr_t     pc_q;
    // Address on the memory port, held while the request is up
    addr_t     req_addr_q;
    // The outstanding fetch belongs to a path that was redirected away
    logic      discard_q;

    logic  mispredict;
    logic  redirect;
    addr_t redirect_pc;
    addr_t next_pc;
    logic  start_fetch;

// ====================
// Redirect and next address
// ====================

    // Wrong direction, or right direction with a wrong target
    assign mispredict = resolve_i.valid &&
                        ((resolve_i.taken != resolve_i.pred_taken) ||
                         (resolve_i.taken && (resolve_i.target != resolve_i.pred_target)));

    assign redirect = trap_i || mispredict;

    // Trap wins over a branch resolved in the same cycle
    always_comb begin
        if (trap_i) begin
            redirect_pc = trap_pc_i;
        end else if (resolve_i.taken) begin
            redirect_pc = resolve_i.target;
        end else begin
            redirect_pc = resolve_i.pc + addr_t'(4);
        end
    end

    assign lookup_pc_o = pc_q;
    assign next_pc     = prediction_i.taken ? prediction_i.target : pc_q + addr_t'(4);

// ====================
// Memory handshake
// ====================

    // A free slot is needed for the fetch that is about to go out
    assign start_fetch = (state_q == IDLE) && !redirect && (free_slots_i != '0);

    assign mem_req_o  = (state_q == WAIT_ACK);
    assign mem_addr_o = req_addr_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            pc_q      <= `FE_RESET_PC;
            discard_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_fetch) begin
                        state_q <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (mem_ack_i) begin
                        state_q   <= WAIT_RELEASE;
                        discard_q <= 1'b0;
                        if (write_o) begin
                            pc_q <= next_pc;
                        end
                    end else if (redirect) begin
                        // Word still in flight, drop it when it arrives
                        discard_q <= 1'b1;
                    end
                end
                WAIT_RELEASE: begin
                    if (!mem_ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
            // A redirect overrides whatever the fetch stream chose
            if (redirect) begin
                pc_q <= redirect_pc;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_fetch) begin
            req_addr_q <= pc_q;
        end
    end

// ====================
// Buffer write
// ====================

    assign flush_o = redirect;
    assign write_o = (state_q == WAIT_ACK) && mem_ack_i && !discard_q && !redirect;

    // pred_target carries the address the fetch stream follows next
    always_comb begin
        write_item_o.pc          = req_addr_q;
        write_item_o.instr       = mem_data_i;
        write_item_o.pred_taken  = prediction_i.taken;
        write_item_o.pred_target = next_pc;
    end

endmodule

//--- source/instruction_buffer.sv
// ====================
// Circular FIFO of fetched items feeding the four-phase issue port
// The head item stays in the FIFO until the back end acknowledges it
// ====================

`timescale 1ns/1ps

`include "fe_defs.svh"

module instruction_buffer (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                write_i,
    input  fe_pkg::fetch_item_t write_item_i,
    output fe_pkg::slot_cnt_t   free_slots_o,
    output logic                issue_req_o,
    output fe_pkg::fetch_item_t issue_item_o,
    input  logic                issue_ack_i
);

    import fe_pkg::*;

    localparam int PTR_BITS = $clog2(`FE_IBUF_DEPTH);

    fetch_item_t         mem_q [`FE_IBUF_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS-1:0] rd_ptr_q;
    slot_cnt_t           count_q;

    hs_state_t   state_q;
    fetch_item_t port_item_q;
    // Set while the item on the port is still the FIFO head
    logic        in_fifo_q;

    logic push;
    logic pop;
    logic launch;

    // Pointer step that also wraps for depths that are not a power of two
    function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(`FE_IBUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

// ====================
// FIFO storage
// ====================

    assign push = write_i && !flush_i && (count_q != slot_cnt_t'(`FE_IBUF_DEPTH));
    // A flushed head is already gone, so its acknowledge pops nothing
    assign pop  = (state_q == WAIT_ACK) && issue_ack_i && in_fifo_q && !flush_i;

    assign free_slots_o = slot_cnt_t'(`FE_IBUF_DEPTH) - count_q;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= write_item_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // Empty the buffer by catching the read side up with the write side
            rd_ptr_q <= wr_ptr_q;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            count_q <= count_q + slot_cnt_t'(push) - slot_cnt_t'(pop);
        end
    end

// ====================
// Issue handshake
// ====================

    assign launch = (state_q == IDLE) && (count_q != '0) && !flush_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            in_fifo_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (launch) begin
                        state_q   <= WAIT_ACK;
                        in_fifo_q <= 1'b1;
                    end
                end
                WAIT_ACK: begin
                    if (issue_ack_i) begin
                        state_q   <= WAIT_RELEASE;
                        in_fifo_q <= 1'b0;
                    end
                end
                WAIT_RELEASE: begin
                    // Back end must release its acknowledge before the next item
                    if (!issue_ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
            if (flush_i) begin
                in_fifo_q <= 1'b0;
            end
        end
    end

    // The port copy stays stable until acknowledged, even across a flush
    always_ff @(posedge clk_i) begin
        if (launch) begin
            port_item_q <= mem_q[rd_ptr_q];
        end
    end

    assign issue_req_o  = (state_q == WAIT_ACK);
    assign issue_item_o = port_item_q;

endmodule

//--- tb/fetch_front_end_asserts.sv
// ====================
// Four-phase handshake assertions
// Bound to the memory port of the PC generator and the issue port of the buffer
// ====================

`timescale 1ns/1ps

module handshake_asserts #(
    parameter int WIDTH = 32
) (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             req_i,
    input logic             ack_i,
    input logic [WIDTH-1:0] payload_i
);

    // Once raised, a request waits for its acknowledge
    req_held_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req_i && !ack_i) |=> req_i)
        else $error("Request dropped before its acknowledge");

    // Address or item must not move while the request is up
    payload_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_i |=> (!req_i || $stable(payload_i)))
        else $error("Payload changed while the request was high");

    // The previous acknowledge has to be released before a new request
    no_early_req_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(req_i) |-> !ack_i)
        else $error("New request raised while the acknowledge was still high");

    reset_idle_a: assert property (@(posedge clk_i)
        !rst_n_i |=> !req_i)
        else $error("Request high after a reset cycle");

endmodule

bind fetch_pc_gen handshake_asserts #(
    .WIDTH ( $bits(fe_pkg::addr_t) )
) mem_hs_asserts_i (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .req_i     ( mem_req_o  ),
    .ack_i     ( mem_ack_i  ),
    .payload_i ( mem_addr_o )
);

bind instruction_buffer handshake_asserts #(
    .WIDTH ( $bits(fe_pkg::fetch_item_t) )
) issue_hs_asserts_i (
    .clk_i     ( clk_i        ),
    .rst_n_i   ( rst_n_i      ),
    .req_i     ( issue_req_o  ),
    .ack_i     ( issue_ack_i  ),
    .payload_i ( issue_item_o )
);

//--- tb/fetch_front_end_tb.sv
// ====================
// Testbench for the fetch front end
// Models the memory and the back end, mirrors the BTB and checks every issued item
// Runs a sequential stream, a trap, two mispredicts and a trained branch
// ====================

`timescale 1ns/1ps

`include "fe_defs.svh"

module fetch_front_end_tb;

    import fe_pkg::*;

    localparam int    NUM_ITEMS   = 46;
    localparam addr_t TRAP_PC     = 32'h0000_0400;
    localparam addr_t BR_TARGET   = 32'h0000_0200;
    // One long back-end stall in the sequential run fills the buffer
    localparam int    STALL_CYC   = 40;
    // Twenty cycles per item cover a slow fetch and a slow issue and get a margin of four
    localparam int    TIMEOUT_CYC = (8 + STALL_CYC + NUM_ITEMS * 20) * 4;

    logic        clk_i;
    logic        rst_n_i;
    logic        mem_req_o;
    addr_t       mem_addr_o;
    logic        mem_ack_i;
    instr_t      mem_data_i;
    logic        issue_req_o;
    fetch_item_t issue_item_o;
    logic        issue_ack_i;
    logic        trap_i;
    addr_t       trap_pc_i;
    resolve_t    resolve_i;

    integer      seed;
    int          items_checked;
    int          mem_delay;
    int          issue_delay;
    addr_t       fetch_addr;
    fetch_item_t held_item;
    fetch_item_t exp_item;
    // The trained branch as it was issued, resolved one item later
    fetch_item_t branch_item;
    string       name;
    // Address that the next issued item has to carry
    addr_t       exp_pc;

    // Reference copy of the BTB that follows the resolutions sent to the DUT
    logic                                   ref_valid   [`FE_BTB_ENTRIES];
    logic [`FE_XLEN-`FE_BTB_INDEX_BITS-3:0] ref_tag     [`FE_BTB_ENTRIES];
    addr_t                                  ref_target  [`FE_BTB_ENTRIES];
    counter_t                               ref_counter [`FE_BTB_ENTRIES];

    fetch_front_end fetch_front_end_i (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .mem_req_o    ( mem_req_o    ),
        .mem_addr_o   ( mem_addr_o   ),
        .mem_ack_i    ( mem_ack_i    ),
        .mem_data_i   ( mem_data_i   ),
        .issue_req_o  ( issue_req_o  ),
        .issue_item_o ( issue_item_o ),
        .issue_ack_i  ( issue_ack_i  ),
        .trap_i       ( trap_i       ),
        .trap_pc_i    ( trap_pc_i    ),
        .resolve_i    ( resolve_i    )
    );

    always #2 clk_i = ~clk_i;

// ====================
// Reference model
// ====================

    // Every address bit takes part in the memory word
    function automatic instr_t mem_word(input addr_t addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'h0000_0013;
    endfunction

    // Expected item at pc where taken means a hit with the counter at 2 or 3
    function automatic fetch_item_t expected_item(input addr_t pc);
        fetch_item_t item;
        btb_index_t  idx;
        logic        hit;
        idx = pc[`FE_BTB_INDEX_BITS+1:2];
        hit = ref_valid[idx] && (ref_tag[idx] == pc[`FE_XLEN-1:`FE_BTB_INDEX_BITS+2]);
        item.pc          = pc;
        item.instr       = mem_word(pc);
        item.pred_taken  = hit && (ref_counter[idx] >= 2'd2);
        item.pred_target = item.pred_taken ? ref_target[idx] : pc + 32'd4;
        return item;
    endfunction

    // Counter steps toward the outcome on a hit and a taken miss allocates weakly taken
    task automatic ref_train(input addr_t pc, input logic taken, input addr_t target);
        btb_index_t idx;
        logic       hit;
        idx = pc[`FE_BTB_INDEX_BITS+1:2];
        hit = ref_valid[idx] && (ref_tag[idx] == pc[`FE_XLEN-1:`FE_BTB_INDEX_BITS+2]);
        if (hit) begin
            if (taken && ref_counter[idx] != 2'd3) begin
                ref_counter[idx] = ref_counter[idx] + 2'd1;
            end else if (!taken && ref_counter[idx] != 2'd0) begin
                ref_counter[idx] = ref_counter[idx] - 2'd1;
            end
            if (taken) begin
                ref_target[idx] = target;
            end
        end else if (taken) begin
            ref_valid[idx]   = 1'b1;
            ref_tag[idx]     = pc[`FE_XLEN-1:`FE_BTB_INDEX_BITS+2];
            ref_target[idx]  = target;
            ref_counter[idx] = 2'd2;
        end
    endtask

    function automatic string test_name(input int n);
        if (n <= 24) return "sequential";
        if (n <= 28) return "trap_redirect";
        if (n <= 31) return "mispredict_taken";
        if (n <= 42) return "trained_prediction";
        return "mispredict_not_taken";
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [`FE_XLEN-1:0] expected,
                               input logic [`FE_XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s expected %h actual %h", test, field, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

// ====================
// Redirect stimulus
// ====================

    task automatic send_trap(input addr_t pc);
        trap_i    <= 1'b1;
        trap_pc_i <= pc;
        exp_pc    = pc;
    endtask

    // Echoes the prediction of the issued item as the back end would
    task automatic send_resolve(input fetch_item_t item, input logic taken, input addr_t target);
        resolve_t res;
        res.valid       = 1'b1;
        res.pc          = item.pc;
        res.taken       = taken;
        res.target      = target;
        res.pred_taken  = item.pred_taken;
        res.pred_target = item.pred_target;
        resolve_i <= res;
        // Wrong direction or taken with a wrong target
        if ((taken != item.pred_taken) || (taken && (target != item.pred_target))) begin
            exp_pc = taken ? target : item.pc + 32'd4;
        end
        ref_train(item.pc, taken, target);
    endtask

    // Item count picks the step of the test sequence
    task automatic apply_action(input int n, input fetch_item_t item);
        case (n)
            24, 31, 38: send_trap(TRAP_PC);
            28:         send_resolve(item, 1'b1, BR_TARGET);
            35:         branch_item = item;
            // Target already issued, so a false redirect would issue it twice
            36:         send_resolve(branch_item, 1'b1, BR_TARGET);
            42:         send_resolve(item, 1'b0, BR_TARGET);
            default:    ;
        endcase
    endtask

// ====================
// Memory and back-end models
// ====================

    // Requests are sampled on the falling edge and answers driven on the rising edge
    always begin
        @(negedge clk_i);
        if (rst_n_i && mem_req_o && !mem_ack_i) begin
            fetch_addr = mem_addr_o;
            mem_delay  = $unsigned($random(seed)) % 4;
            repeat (mem_delay) @(posedge clk_i);
            @(posedge clk_i);
            mem_ack_i  <= 1'b1;
            mem_data_i <= mem_word(fetch_addr);
            do begin
                @(negedge clk_i);
            end while (mem_req_o);
            @(posedge clk_i);
            mem_ack_i <= 1'b0;
        end
    end

    // Redirects go out in the cycle after the acknowledge drops while the port is idle
    always begin
        @(negedge clk_i);
        if (rst_n_i && issue_req_o && !issue_ack_i) begin
            held_item   = issue_item_o;
            issue_delay = $unsigned($random(seed)) % 4;
            // Holding one item long enough lets fetch run into a full buffer
            if (items_checked == 8) begin
                issue_delay = issue_delay + STALL_CYC;
            end
            repeat (issue_delay) @(posedge clk_i);
            @(posedge clk_i);
            issue_ack_i <= 1'b1;
            do begin
                @(negedge clk_i);
            end while (issue_req_o);
            @(posedge clk_i);
            issue_ack_i <= 1'b0;
            apply_action(items_checked, held_item);
            @(posedge clk_i);
            trap_i    <= 1'b0;
            resolve_i <= '0;
        end
    end

// ====================
// Checking, run control and watchdog
// ====================

    // An item is accepted in the one cycle where request and acknowledge are both high
    always @(negedge clk_i) begin
        if (rst_n_i && issue_req_o && issue_ack_i) begin
            exp_item = expected_item(exp_pc);
            name     = test_name(items_checked + 1);
            check_value(name, "pc", exp_item.pc, issue_item_o.pc);
            check_value(name, "instr", exp_item.instr, issue_item_o.instr);
            check_value(name, "pred_taken", 32'(exp_item.pred_taken), 32'(issue_item_o.pred_taken));
            check_value(name, "pred_target", exp_item.pred_target, issue_item_o.pred_target);
            exp_pc        = exp_item.pred_target;
            items_checked = items_checked + 1;
        end
    end

    initial begin
        seed          = 32'h9366;
        items_checked = 0;
        exp_pc        = `FE_RESET_PC;
        for (int i = 0; i < `FE_BTB_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
        end
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        mem_ack_i   = 1'b0;
        mem_data_i  = '0;
        issue_ack_i = 1'b0;
        trap_i      = 1'b0;
        trap_pc_i   = '0;
        resolve_i   = '0;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        wait (items_checked == NUM_ITEMS);
        repeat (4) @(posedge clk_i);
        $display("sim passed");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk_i);
        $display("Timeout, only %0d of %0d items were issued", items_checked, NUM_ITEMS);
        $display("sim failed");
        $fatal(1);
    end

endmodule
